// ==== tb.f ====
ahb_pkg.sv
ahb_cfg_pkg.sv
ahb_addr_decoder.sv
ahb_default_slave.sv
ahb_resp_mux.sv
ahb_node.sv
ahb_sram_slave.sv
ahb_subsystem.sv
tb_clock_gen.sv
tb_ahb_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the AHB subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_subsystem
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_ahb_subsystem.sv ====
////////////////////
// Directed testbench for the AHB subsystem
// pipelined master driver, memory model, timeout
////////////////////

`timescale 1ns/1ps

module tb_ahb_subsystem;

  localparam int NB_SLAVES = 4;
  localparam int MEM_WORDS = 64;
  // Transfers per test: 16, 21, 16, 5, 6
  // at most 3 cycles each, one drain cycle per queue, plus reset
  localparam int TEST_CYCLES    = (16 + 21 + 16 + 5 + 6) * 3 + 8 + 8;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic                       hclk;
  logic                       reset;
  logic [31:0]                haddr;
  logic [31:0]                hwdata;
  logic                       hsel;
  logic                       hwrite;
  logic                       hmastlock;
  logic [1:0]                 htrans;
  logic [3:0]                 hprot;
  logic [2:0]                 hburst;
  logic [2:0]                 hsize;
  logic [31:0]                hrdata;
  logic                       hready;
  logic                       hresp;
  logic [NB_SLAVES-1:0][31:0] start_addr;
  logic [NB_SLAVES-1:0][31:0] end_addr;

  // Pending transfers, one entry per address phase
  logic [31:0] q_addr  [$];
  logic        q_write [$];
  logic [2:0]  q_size  [$];
  logic [1:0]  q_trans [$];
  logic        q_sel   [$];
  logic [31:0] q_wdata [$];

  // Expected SRAM contents per slave
  logic [31:0] model_mem [NB_SLAVES][MEM_WORDS];

  int seed;
  int errors    = 0;
  int checks    = 0;
  int cycle_cnt = 0;

  tb_clock_gen #(.PERIOD_NS(100)) clock_inst (.clk_o(hclk));

  ahb_subsystem #(
    .NB_SLAVES      (NB_SLAVES),
    .AHB_DATA_WIDTH (32),
    .AHB_ADDR_WIDTH (32),
    .BYPASS_HSEL    (1'b0),
    .MEM_WORDS      (MEM_WORDS)
  ) ahb_subsystem_inst (
    .hclk_i         (hclk),
    .reset_i        (reset),
    .haddr_i        (haddr),
    .hwdata_i       (hwdata),
    .hsel_i         (hsel),
    .hwrite_i       (hwrite),
    .hmastlock_i    (hmastlock),
    .htrans_i       (htrans),
    .hprot_i        (hprot),
    .hburst_i       (hburst),
    .hsize_i        (hsize),
    .hrdata_o       (hrdata),
    .hmasterready_o (hready),
    .hresp_o        (hresp),
    .start_addr_i   (start_addr),
    .end_addr_i     (end_addr)
  );

  // Run limit
  always @(posedge hclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout, no end of test after %0d cycles", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp_v, act_v);
    end
  endtask

  // Slave k owns 0x1000*k .. 0x1000*k + 0xFF, else -1
  function automatic int slave_of(input logic [31:0] addr);
    int k;
    k = int'(addr >> 12);
    if (k < NB_SLAVES && addr[11:0] <= 12'h0FF) begin
      return k;
    end
    return -1;
  endfunction

  // Byte lanes written for a given address and size
  function automatic logic [31:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
    case (size)
      ahb_pkg::HSIZE_BYTE: return 32'h0000_00FF << (8 * addr[1:0]);
      ahb_pkg::HSIZE_HALF: return 32'h0000_FFFF << (16 * addr[1]);
      default:             return 32'hFFFF_FFFF;
    endcase
  endfunction

  function automatic logic is_active(input int j);
    return q_sel[j] && (q_trans[j] == ahb_pkg::HTRANS_NONSEQ ||
                        q_trans[j] == ahb_pkg::HTRANS_SEQ);
  endfunction

  task automatic push_xfer(input logic [31:0] addr, input logic write, input logic [2:0] size,
                           input logic [1:0] trans, input logic sel);
    q_addr.push_back(addr);
    q_write.push_back(write);
    q_size.push_back(size);
    q_trans.push_back(trans);
    q_sel.push_back(sel);
    q_wdata.push_back($random(seed));
  endtask

  task automatic push_write(input logic [31:0] addr, input logic [2:0] size);
    push_xfer(addr, 1'b1, size, ahb_pkg::HTRANS_NONSEQ, 1'b1);
  endtask

  task automatic push_read(input logic [31:0] addr);
    push_xfer(addr, 1'b0, ahb_pkg::HSIZE_WORD, ahb_pkg::HTRANS_NONSEQ, 1'b1);
  endtask

  task automatic drive_idle();
    haddr  = '0;
    hwrite = 1'b0;
    hsize  = ahb_pkg::HSIZE_WORD;
    htrans = ahb_pkg::HTRANS_IDLE;
    hsel   = 1'b0;
  endtask

  // Checks the data phase of entry j once hready is high
  task automatic check_data_phase(input int j, input int waits);
    int          slv;
    int          idx;
    logic [31:0] mask;
    slv = slave_of(q_addr[j]);
    idx = int'((q_addr[j] >> 2) % MEM_WORDS);
    if (is_active(j) && slv >= 0) begin
      // Slave k stalls k mod 3 cycles
      check_val("hready low cycles", 32'(slv % 3), 32'(waits));
      check_val("hresp", 32'(ahb_pkg::HRESP_OKAY), 32'(hresp));
      if (q_write[j]) begin
        mask = lane_mask(q_addr[j], q_size[j]);
        model_mem[slv][idx] = (model_mem[slv][idx] & ~mask) | (q_wdata[j] & mask);
      end else begin
        check_val("hrdata", model_mem[slv][idx], hrdata);
      end
    end else if (is_active(j)) begin
      // Unmapped, one stalled ERROR cycle first and no read data
      check_val("hready low cycles", 32'd1, 32'(waits));
      check_val("hresp", 32'(ahb_pkg::HRESP_ERROR), 32'(hresp));
      check_val("hrdata", 32'd0, hrdata);
    end else begin
      check_val("hready low cycles", 32'd0, 32'(waits));
      check_val("hresp", 32'(ahb_pkg::HRESP_OKAY), 32'(hresp));
    end
  endtask

  // Master: address phase i overlaps data phase i-1
  // called and left 1 ns after a rising edge
  task automatic run_queue();
    int n;
    int waits;
    n = q_addr.size();
    for (int i = 0; i <= n; i++) begin
      if (i < n) begin
        haddr  = q_addr[i];
        hwrite = q_write[i];
        hsize  = q_size[i];
        htrans = q_trans[i];
        hsel   = q_sel[i];
      end else begin
        drive_idle();
      end
      if (i > 0) begin
        hwdata = q_wdata[i-1];
      end
      // Sample mid-cycle, inputs held while stalled
      waits = 0;
      @(negedge hclk);
      while (!hready) begin
        if (i > 0) begin
          check_val("hresp", 32'(is_active(i-1) && slave_of(q_addr[i-1]) < 0), 32'(hresp));
        end
        waits++;
        @(negedge hclk);
      end
      if (i > 0) begin
        check_data_phase(i - 1, waits);
      end
      @(posedge hclk);
      #1;
    end
    q_addr.delete();
    q_write.delete();
    q_size.delete();
    q_trans.delete();
    q_sel.delete();
    q_wdata.delete();
  endtask

  // Every slave written before any read
  // so a misrouted transfer reads back another slave's word
  task automatic test_word_routing();
    logic [31:0] base;
    for (int k = 0; k < NB_SLAVES; k++) begin
      base = 32'(k) << 12;
      push_write(base + 32'h10, ahb_pkg::HSIZE_WORD);
      push_write(base + 32'hFC, ahb_pkg::HSIZE_WORD);
    end
    for (int k = 0; k < NB_SLAVES; k++) begin
      base = 32'(k) << 12;
      push_read(base + 32'h10);
      push_read(base + 32'hFC);
    end
    run_queue();
  endtask

  task automatic test_byte_lanes();
    logic [31:0] a;
    for (int k = 0; k < 3; k++) begin
      a = (32'(k) << 12) + 32'h40;
      push_write(a, ahb_pkg::HSIZE_WORD);
      push_write(a + 32'd1, ahb_pkg::HSIZE_BYTE);
      push_write(a + 32'd2, ahb_pkg::HSIZE_HALF);
      push_read(a);
      push_write(a + 32'd3, ahb_pkg::HSIZE_BYTE);
      push_write(a, ahb_pkg::HSIZE_HALF);
      push_read(a);
      run_queue();
    end
  endtask

  // Stalling slave against zero-wait slave, back to back
  task automatic test_pipelined_alternation();
    logic [31:0] sa;
    logic [31:0] sb;
    for (int p = 0; p < 2; p++) begin
      sa = (p == 0) ? 32'h2080 : 32'h1080;
      sb = (p == 0) ? 32'h0080 : 32'h3080;
      for (int r = 0; r < 2; r++) begin
        push_write(sa + 32'(4 * r), ahb_pkg::HSIZE_WORD);
        push_write(sb + 32'(4 * r), ahb_pkg::HSIZE_WORD);
      end
      for (int r = 0; r < 2; r++) begin
        push_read(sa + 32'(4 * r));
        push_read(sb + 32'(4 * r));
      end
      run_queue();
    end
  endtask

  // 0x1100 sits just past slave 1
  task automatic test_unmapped_error();
    push_write(32'h1020, ahb_pkg::HSIZE_WORD);
    push_read(32'h1100);
    push_read(32'h1020);
    push_write(32'h5000, ahb_pkg::HSIZE_WORD);
    push_read(32'h1020);
    run_queue();
  endtask

  task automatic test_unselected_and_idle();
    push_write(32'h0030, ahb_pkg::HSIZE_WORD);
    push_write(32'h2030, ahb_pkg::HSIZE_WORD);
    push_xfer(32'h0030, 1'b1, ahb_pkg::HSIZE_WORD, ahb_pkg::HTRANS_NONSEQ, 1'b0);
    push_xfer(32'h2030, 1'b1, ahb_pkg::HSIZE_WORD, ahb_pkg::HTRANS_IDLE, 1'b1);
    push_read(32'h0030);
    push_read(32'h2030);
    run_queue();
  endtask

  initial begin
    seed = 32'hbfd6_d3af;
    reset = 1'b1;
    drive_idle();
    hwdata    = '0;
    hmastlock = 1'b0;
    hprot     = 4'b0011;
    hburst    = ahb_pkg::HBURST_SINGLE;
    for (int k = 0; k < NB_SLAVES; k++) begin
      start_addr[k] = 32'(k) << 12;
      end_addr[k]   = (32'(k) << 12) + 32'hFF;
    end
    repeat (2) @(posedge hclk);
    #1;
    reset = 1'b0;
    // Idle bus after reset
    @(negedge hclk);
    check_val("hready", 32'd1, 32'(hready));
    check_val("hresp", 32'(ahb_pkg::HRESP_OKAY), 32'(hresp));
    @(posedge hclk);
    #1;
    test_word_routing();
    test_byte_lanes();
    test_pipelined_alternation();
    test_unmapped_error();
    test_unselected_and_idle();
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
////////////////////
// Testbench clock source
////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk_o
);

  // Starts low, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

// ==== ahb_subsystem.sv ====
////////////////////
// AHB node with NB_SLAVES SRAM slaves
////////////////////

`timescale 1ns/1ps

module ahb_subsystem #(
  parameter int NB_SLAVES      = ahb_cfg_pkg::DEF_NB_SLAVES,
  parameter int AHB_DATA_WIDTH = ahb_cfg_pkg::DEF_DATA_WIDTH,
  parameter int AHB_ADDR_WIDTH = ahb_cfg_pkg::DEF_ADDR_WIDTH,
  parameter bit BYPASS_HSEL    = 1'b0,
  parameter int MEM_WORDS      = ahb_cfg_pkg::DEF_MEM_WORDS
) (
  input  logic                                     hclk_i,
  input  logic                                     reset_i,
  input  logic [AHB_ADDR_WIDTH-1:0]                haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0]                hwdata_i,
  input  logic                                     hsel_i,
  input  logic                                     hwrite_i,
  input  logic                                     hmastlock_i,
  input  logic [1:0]                               htrans_i,
  input  logic [3:0]                               hprot_i,
  input  logic [2:0]                               hburst_i,
  input  logic [2:0]                               hsize_i,
  output logic [AHB_DATA_WIDTH-1:0]                hrdata_o,
  output logic                                     hmasterready_o,
  output logic                                     hresp_o,
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] start_addr_i,
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] end_addr_i
);

  // Slave lanes
  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] s_haddr;
  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] s_hwdata;
  logic [NB_SLAVES-1:0]                     s_hsel;
  logic [NB_SLAVES-1:0]                     s_hwrite;
  logic [NB_SLAVES-1:0]                     s_hready;
  logic [NB_SLAVES-1:0][1:0]                s_htrans;
  logic [NB_SLAVES-1:0][2:0]                s_hsize;
  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] s_hrdata;
  logic [NB_SLAVES-1:0]                     s_hreadyout;
  logic [NB_SLAVES-1:0]                     s_hresp;

  ahb_node #(
    .NB_SLAVES      (NB_SLAVES),
    .AHB_DATA_WIDTH (AHB_DATA_WIDTH),
    .AHB_ADDR_WIDTH (AHB_ADDR_WIDTH),
    .BYPASS_HSEL    (BYPASS_HSEL)
  ) node_inst (
    .hclk_i         (hclk_i),
    .reset_i        (reset_i),
    .haddr_i        (haddr_i),
    .hwdata_i       (hwdata_i),
    .hsel_i         (hsel_i),
    .hwrite_i       (hwrite_i),
    .hmastlock_i    (hmastlock_i),
    .htrans_i       (htrans_i),
    .hprot_i        (hprot_i),
    .hburst_i       (hburst_i),
    .hsize_i        (hsize_i),
    .hrdata_o       (hrdata_o),
    .hmasterready_o (hmasterready_o),
    .hresp_o        (hresp_o),
    .haddr_o        (s_haddr),
    .hwdata_o       (s_hwdata),
    .hsel_o         (s_hsel),
    .hwrite_o       (s_hwrite),
    // SRAM slaves ignore lock, protection and burst
    .hmastlock_o    (),
    .hslaveready_o  (s_hready),
    .htrans_o       (s_htrans),
    .hprot_o        (),
    .hburst_o       (),
    .hsize_o        (s_hsize),
    .hrdata_i       (s_hrdata),
    .hreadyout_i    (s_hreadyout),
    .hresp_i        (s_hresp),
    .start_addr_i   (start_addr_i),
    .end_addr_i     (end_addr_i)
  );

  // Wait states cycle 0, 1, 2 across the slaves
  for (genvar k = 0; k < NB_SLAVES; k++) begin : g_slave
    ahb_sram_slave #(
      .AHB_DATA_WIDTH (AHB_DATA_WIDTH),
      .AHB_ADDR_WIDTH (AHB_ADDR_WIDTH),
      .MEM_WORDS      (MEM_WORDS),
      .WAIT_STATES    (k % 3)
    ) sram_inst (
      .hclk_i      (hclk_i),
      .reset_i     (reset_i),
      .hsel_i      (s_hsel[k]),
      .haddr_i     (s_haddr[k]),
      .hwdata_i    (s_hwdata[k]),
      .hwrite_i    (s_hwrite[k]),
      .hsize_i     (s_hsize[k]),
      .htrans_i    (s_htrans[k]),
      .hready_i    (s_hready[k]),
      .hrdata_o    (s_hrdata[k]),
      .hreadyout_o (s_hreadyout[k]),
      .hresp_o     (s_hresp[k])
    );
  end

endmodule

// ==== ahb_sram_slave.sv ====
////////////////////
// SRAM slave with byte lanes and fixed wait states
////////////////////

`timescale 1ns/1ps

module ahb_sram_slave #(
  parameter int AHB_DATA_WIDTH = ahb_cfg_pkg::DEF_DATA_WIDTH,
  parameter int AHB_ADDR_WIDTH = ahb_cfg_pkg::DEF_ADDR_WIDTH,
  parameter int MEM_WORDS      = ahb_cfg_pkg::DEF_MEM_WORDS,
  parameter int WAIT_STATES    = 0
) (
  input  logic                      hclk_i,
  input  logic                      reset_i,
  input  logic                      hsel_i,
  input  logic [AHB_ADDR_WIDTH-1:0] haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0] hwdata_i,
  input  logic                      hwrite_i,
  input  logic [2:0]                hsize_i,
  input  logic [1:0]                htrans_i,
  input  logic                      hready_i,
  output logic [AHB_DATA_WIDTH-1:0] hrdata_o,
  output logic                      hreadyout_o,
  output logic                      hresp_o
);

  localparam int NB_BYTES = AHB_DATA_WIDTH / 8;
  localparam int OFF_W    = $clog2(NB_BYTES);
  localparam int IDX_W    = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W    = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [AHB_DATA_WIDTH-1:0] mem [MEM_WORDS];

  // Data-phase state
  logic                 active_q;
  logic [CNT_W-1:0]     cnt_q;
  // Captured address-phase controls
  logic                 write_q;
  logic [IDX_W-1:0]     idx_q;
  logic [OFF_W-1:0]     off_q;
  logic [2:0]           size_q;
  logic                 accept;
  logic                 last;
  logic [OFF_W-1:0]     keep_mask;
  logic [NB_BYTES-1:0]  byte_en;

  assign accept = hsel_i && hready_i &&
                  ((htrans_i == ahb_pkg::HTRANS_NONSEQ) ||
                   (htrans_i == ahb_pkg::HTRANS_SEQ));

  // Final cycle of the data phase
  assign last = (cnt_q == CNT_W'(WAIT_STATES));

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (hready_i) begin
      // Previous data phase done, maybe start another
      active_q <= accept;
      cnt_q    <= '0;
    end else if (active_q && !last) begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  // Word index wraps on the memory depth
  always_ff @(posedge hclk_i) begin
    if (accept) begin
      write_q <= hwrite_i;
      idx_q   <= IDX_W'((haddr_i >> OFF_W) % MEM_WORDS);
      off_q   <= haddr_i[OFF_W-1:0];
      size_q  <= hsize_i;
    end
  end

  // Offset bits that must match for a lane to be written
  always_comb begin
    case (size_q)
      ahb_pkg::HSIZE_BYTE: keep_mask = '1;
      ahb_pkg::HSIZE_HALF: keep_mask = {OFF_W{1'b1}} << 1;
      default:             keep_mask = '0;
    endcase
    for (int b = 0; b < NB_BYTES; b++) begin
      byte_en[b] = ((OFF_W'(b) ^ off_q) & keep_mask) == '0;
    end
  end

  // Commit on the edge that closes the data phase
  always_ff @(posedge hclk_i) begin
    if (active_q && write_q && hready_i) begin
      for (int b = 0; b < NB_BYTES; b++) begin
        if (byte_en[b]) begin
          mem[idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read word sampled by the master once ready goes high
  assign hrdata_o    = mem[idx_q];
  assign hreadyout_o = !active_q || last;
  assign hresp_o     = ahb_pkg::HRESP_OKAY;

endmodule

// ==== ahb_node.sv ====
////////////////////
// AHB-Lite node, one master to NB_SLAVES slaves
////////////////////

`timescale 1ns/1ps

module ahb_node #(
  parameter int NB_SLAVES      = ahb_cfg_pkg::DEF_NB_SLAVES,
  parameter int AHB_DATA_WIDTH = ahb_cfg_pkg::DEF_DATA_WIDTH,
  parameter int AHB_ADDR_WIDTH = ahb_cfg_pkg::DEF_ADDR_WIDTH,
  parameter bit BYPASS_HSEL    = 1'b0
) (
  input  logic                                     hclk_i,
  input  logic                                     reset_i,
  // Master side
  input  logic [AHB_ADDR_WIDTH-1:0]                haddr_i,
  input  logic [AHB_DATA_WIDTH-1:0]                hwdata_i,
  input  logic                                     hsel_i,
  input  logic                                     hwrite_i,
  input  logic                                     hmastlock_i,
  input  logic [1:0]                               htrans_i,
  input  logic [3:0]                               hprot_i,
  input  logic [2:0]                               hburst_i,
  input  logic [2:0]                               hsize_i,
  output logic [AHB_DATA_WIDTH-1:0]                hrdata_o,
  output logic                                     hmasterready_o,
  output logic                                     hresp_o,
  // Slave side, one lane per slave
  output logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] haddr_o,
  output logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] hwdata_o,
  output logic [NB_SLAVES-1:0]                     hsel_o,
  output logic [NB_SLAVES-1:0]                     hwrite_o,
  output logic [NB_SLAVES-1:0]                     hmastlock_o,
  output logic [NB_SLAVES-1:0]                     hslaveready_o,
  output logic [NB_SLAVES-1:0][1:0]                htrans_o,
  output logic [NB_SLAVES-1:0][3:0]                hprot_o,
  output logic [NB_SLAVES-1:0][2:0]                hburst_o,
  output logic [NB_SLAVES-1:0][2:0]                hsize_o,
  input  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] hrdata_i,
  input  logic [NB_SLAVES-1:0]                     hreadyout_i,
  input  logic [NB_SLAVES-1:0]                     hresp_i,
  // Address map
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] start_addr_i,
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] end_addr_i
);

  logic [NB_SLAVES-1:0] dec_sel;
  logic                 dec_nomatch;
  logic                 hsel_eff;
  logic                 def_hsel;
  logic                 def_hreadyout;
  logic                 def_hresp;
  logic                 hready;

  ahb_addr_decoder #(
    .NB_SLAVES      (NB_SLAVES),
    .AHB_ADDR_WIDTH (AHB_ADDR_WIDTH)
  ) decoder_inst (
    .haddr_i      (haddr_i),
    .start_addr_i (start_addr_i),
    .end_addr_i   (end_addr_i),
    .sel_o        (dec_sel),
    .nomatch_o    (dec_nomatch)
  );

  // Bypass treats every transfer as ours
  assign hsel_eff = BYPASS_HSEL ? 1'b1 : hsel_i;

  // Per-slave select, gated by master hsel
  assign hsel_o = dec_sel & {NB_SLAVES{hsel_eff}};

  // Default slave sees only selected unmapped transfers
  assign def_hsel = hsel_eff & dec_nomatch;

  ahb_default_slave default_slave_inst (
    .hclk_i      (hclk_i),
    .reset_i     (reset_i),
    .hsel_i      (def_hsel),
    .htrans_i    (htrans_i),
    .hready_i    (hready),
    .hreadyout_o (def_hreadyout),
    .hresp_o     (def_hresp)
  );

  // No slave selected, default slave owns the data phase
  // it is idle then unless the transfer was unmapped
  ahb_resp_mux #(
    .NB_SLAVES      (NB_SLAVES),
    .AHB_DATA_WIDTH (AHB_DATA_WIDTH)
  ) resp_mux_inst (
    .hclk_i          (hclk_i),
    .reset_i         (reset_i),
    .hready_i        (hready),
    .sel_i           (hsel_o),
    .def_sel_i       (~|hsel_o),
    .hrdata_i        (hrdata_i),
    .hreadyout_i     (hreadyout_i),
    .hresp_i         (hresp_i),
    .def_hreadyout_i (def_hreadyout),
    .def_hresp_i     (def_hresp),
    .hrdata_o        (hrdata_o),
    .hready_o        (hready),
    .hresp_o         (hresp_o)
  );

  assign hmasterready_o = hready;

  // Broadcast to every slave lane
  for (genvar i = 0; i < NB_SLAVES; i++) begin : g_lane
    assign haddr_o[i]       = haddr_i;
    assign hwdata_o[i]      = hwdata_i;
    assign hwrite_o[i]      = hwrite_i;
    assign hmastlock_o[i]   = hmastlock_i;
    assign htrans_o[i]      = htrans_i;
    assign hprot_o[i]       = hprot_i;
    assign hburst_o[i]      = hburst_i;
    assign hsize_o[i]       = hsize_i;
    assign hslaveready_o[i] = hready;
  end

endmodule

// ==== ahb_resp_mux.sv ====
////////////////////
// Data-phase owner register and response mux
////////////////////

`timescale 1ns/1ps

module ahb_resp_mux #(
  parameter int NB_SLAVES      = ahb_cfg_pkg::DEF_NB_SLAVES,
  parameter int AHB_DATA_WIDTH = ahb_cfg_pkg::DEF_DATA_WIDTH
) (
  input  logic                                     hclk_i,
  input  logic                                     reset_i,
  input  logic                                     hready_i,
  input  logic [NB_SLAVES-1:0]                     sel_i,
  input  logic                                     def_sel_i,
  input  logic [NB_SLAVES-1:0][AHB_DATA_WIDTH-1:0] hrdata_i,
  input  logic [NB_SLAVES-1:0]                     hreadyout_i,
  input  logic [NB_SLAVES-1:0]                     hresp_i,
  input  logic                                     def_hreadyout_i,
  input  logic                                     def_hresp_i,
  output logic [AHB_DATA_WIDTH-1:0]                hrdata_o,
  output logic                                     hready_o,
  output logic                                     hresp_o
);

  // One-hot slave owner, or the default slave
  logic [NB_SLAVES-1:0] owner_q;
  logic                 owner_def_q;

  // Owner moves only when the current data phase ends
  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      owner_q     <= '0;
      owner_def_q <= 1'b1;
    end else if (hready_i) begin
      owner_q     <= sel_i;
      owner_def_q <= def_sel_i;
    end
  end

  always_comb begin
    hrdata_o = '0;
    hready_o = 1'b0;
    hresp_o  = ahb_pkg::HRESP_OKAY;
    if (owner_def_q) begin
      // Default slave returns no data
      hready_o = def_hreadyout_i;
      hresp_o  = def_hresp_i;
    end else begin
      for (int i = 0; i < NB_SLAVES; i++) begin
        if (owner_q[i]) begin
          hrdata_o = hrdata_i[i];
          hready_o = hreadyout_i[i];
          hresp_o  = hresp_i[i];
        end
      end
    end
  end

endmodule

// ==== ahb_default_slave.sv ====
////////////////////
// Default slave, two-cycle ERROR for unmapped transfers
////////////////////

`timescale 1ns/1ps

module ahb_default_slave (
  input  logic       hclk_i,
  input  logic       reset_i,
  input  logic       hsel_i,
  input  logic [1:0] htrans_i,
  input  logic       hready_i,
  output logic       hreadyout_o,
  output logic       hresp_o
);

  // State encoding
  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_ERR_FIRST  = 2'd1;
  localparam logic [1:0] ST_ERR_SECOND = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       accept;

  // Only NONSEQ and SEQ are real transfers
  assign accept = hsel_i && hready_i &&
                  ((htrans_i == ahb_pkg::HTRANS_NONSEQ) ||
                   (htrans_i == ahb_pkg::HTRANS_SEQ));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_ERR_FIRST;
        end
      end
      // First ERROR cycle always stalls
      ST_ERR_FIRST: begin
        state_d = ST_ERR_SECOND;
      end
      // Ready is high here, so a new transfer may land
      default: begin
        state_d = accept ? ST_ERR_FIRST : ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Low only in the first ERROR cycle
  assign hreadyout_o = (state_q != ST_ERR_FIRST);
  assign hresp_o     = (state_q == ST_IDLE) ? ahb_pkg::HRESP_OKAY : ahb_pkg::HRESP_ERROR;

endmodule

// ==== ahb_addr_decoder.sv ====
////////////////////
// Address range decoder
// lowest index wins on overlap
////////////////////

`timescale 1ns/1ps

module ahb_addr_decoder #(
  parameter int NB_SLAVES      = ahb_cfg_pkg::DEF_NB_SLAVES,
  parameter int AHB_ADDR_WIDTH = ahb_cfg_pkg::DEF_ADDR_WIDTH
) (
  input  logic [AHB_ADDR_WIDTH-1:0]                haddr_i,
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] start_addr_i,
  input  logic [NB_SLAVES-1:0][AHB_ADDR_WIDTH-1:0] end_addr_i,
  output logic [NB_SLAVES-1:0]                     sel_o,
  output logic                                     nomatch_o
);

  // Raw range hits, may hold more than one bit
  logic [NB_SLAVES-1:0] hit;

  // Inclusive compare, start <= haddr <= end
  always_comb begin
    for (int i = 0; i < NB_SLAVES; i++) begin
      hit[i] = (haddr_i >= start_addr_i[i]) && (haddr_i <= end_addr_i[i]);
    end
  end

  // Isolate lowest set bit
  // two's complement trick, x & -x
  assign sel_o = hit & (~hit + NB_SLAVES'(1));

  // Nothing hit, default slave takes it
  assign nomatch_o = ~|hit;

endmodule

// ==== ahb_cfg_pkg.sv ====
////////////////////
// Default sizes for the AHB node and subsystem
////////////////////

package ahb_cfg_pkg;

  // Slave ports on the node
  localparam int DEF_NB_SLAVES = 4;

  // Bus widths in bits
  localparam int DEF_DATA_WIDTH = 32;
  localparam int DEF_ADDR_WIDTH = 32;

  // SRAM depth in data words
  // Address wraps modulo this depth
  localparam int DEF_MEM_WORDS = 64;

endpackage

// ==== ahb_pkg.sv ====
////////////////////
// AHB-Lite protocol encodings
// htrans, hsize, hburst and hresp
////////////////////

package ahb_pkg;

  // Transfer type on htrans
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;

  // Transfer size on hsize
  // Only sizes up to one 32-bit word are used here
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  // Burst kind on hburst
  // Passed through by the node, never decoded
  localparam logic [2:0] HBURST_SINGLE = 3'b000;
  localparam logic [2:0] HBURST_INCR   = 3'b001;

  // Slave response on hresp
  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

endpackage
